/* files.f */
csr_issue_pkg.sv
csr_issue_ctrl.sv
csr_entry_store.sv
csr_squash_locator.sv
fence_sequencer.sv
csr_issue_top.sv
tb_csr_issue.sv

/* Makefile */
SIM = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = tb_csr_issue
FILELIST = files.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* tb_csr_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_issue;

    localparam int depth = 8;
    localparam int period = 8;
    localparam int test_cycles = 400;
    localparam int num_tests = 6;
    localparam int csrop_w = csr_issue_pkg::csrop_width;

    logic clk;
    logic rst;
    logic dis_en;
    logic commit_fence;
    logic redirect;
    logic exec_ready;
    csr_issue_pkg::csr_dis_t dis_data;
    csr_issue_pkg::rob_idx_t commit_rob_idx;
    csr_issue_pkg::rob_idx_t redirect_idx;
    csr_issue_pkg::fence_ack_t fence_ack;
    logic full;
    logic issue_valid;
    csr_issue_pkg::csr_issue_t issue_data;
    logic fence_req;
    logic [31:0] trap_inst;
    csr_issue_pkg::fence_ctrl_t fence_ctrl;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_errs0;
    csr_issue_pkg::csr_dis_t model_q[$];
    csr_issue_pkg::rob_idx_t rob_ctr; // next ROB index handed to a dispatched entry.
    logic [csr_issue_pkg::vaddr_width-1:0] vaddr_m;
    logic [csr_issue_pkg::asid_width-1:0] asid_m;
    csr_issue_pkg::rob_idx_t fence_rob_m;

    csr_issue_top #(
        .queue_depth(depth)
    ) csr_issue_top_inst (
        .clk(clk),
        .rst(rst),
        .dis_en(dis_en),
        .dis_data(dis_data),
        .commit_rob_idx(commit_rob_idx),
        .commit_fence(commit_fence),
        .redirect(redirect),
        .redirect_idx(redirect_idx),
        .exec_ready(exec_ready),
        .fence_ack(fence_ack),
        .full(full),
        .issue_valid(issue_valid),
        .issue_data(issue_data),
        .fence_req(fence_req),
        .trap_inst(trap_inst),
        .fence_ctrl(fence_ctrl)
    );

    always #(period / 2) clk = ~clk;

    initial begin
        #((num_tests * test_cycles + 16) * period);
        $display("timeout: the tests did not finish in time.");
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_issue(input csr_issue_pkg::csr_issue_t got,
                               input csr_issue_pkg::csr_issue_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: issue_data %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_fence(input csr_issue_pkg::fence_ctrl_t got,
                               input csr_issue_pkg::fence_ctrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: fence_ctrl %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: trap_inst %h expected %h", $time, got, exp);
        end
    endtask

    function automatic csr_issue_pkg::rob_idx_t rob_add(input csr_issue_pkg::rob_idx_t r,
                                                        input int n);
        logic [csr_issue_pkg::rob_width-1:0] v;
        v = r + 7'(n); // the carry out of the index flips the wrap bit.
        return csr_issue_pkg::rob_idx_t'(v);
    endfunction

    // fence kinds, and writes to the status, translation and pmp CSRs, serialize.
    function automatic logic needs_serial(input csr_issue_pkg::csr_dis_t e);
        logic [csr_issue_pkg::csr_id_width-1:0] id;
        id = e.csr_id;
        return e.csrop[3] || id == 12'h300 || id == 12'h100 || id == 12'h180 ||
               id == 12'h003 || (id >= 12'h3a0 && id < 12'h3f0);
    endfunction

    function automatic csr_issue_pkg::csr_dis_t rand_entry(input csr_issue_pkg::rob_idx_t rob,
                                                           input logic allow_fence);
        csr_issue_pkg::csr_dis_t e;
        logic [csrop_w-1:0] ops [6];
        ops = '{csr_issue_pkg::op_csrrw, csr_issue_pkg::op_csrrs, csr_issue_pkg::op_csrrc,
                csr_issue_pkg::op_fence, csr_issue_pkg::op_fencei, csr_issue_pkg::op_sfence};
        e.we = 1'($urandom);
        e.rd = 7'($urandom);
        e.rob_idx = rob;
        e.csrop = ops[allow_fence ? $urandom % 6 : $urandom % 3];
        case ($urandom % 8)
            0: e.csr_id = csr_issue_pkg::csr_mstatus;
            1: e.csr_id = csr_issue_pkg::csr_sstatus;
            2: e.csr_id = csr_issue_pkg::csr_satp;
            3: e.csr_id = csr_issue_pkg::csr_fcsr;
            4: e.csr_id = 12'(csr_issue_pkg::csr_pmp_base + $urandom % 80);
            5: e.csr_id = csr_issue_pkg::csr_pmp_limit;
            6: e.csr_id = csr_issue_pkg::csr_pmp_base - 12'd1;
            default: e.csr_id = 12'($urandom);
        endcase
        e.src1 = {$urandom, $urandom};
        e.src2 = {$urandom, $urandom};
        e.inst = $urandom;
        return e;
    endfunction

    task automatic reset_dut();
        rst = 1'b1;
        dis_en = 1'b0;
        dis_data = '0;
        commit_fence = 1'b0;
        redirect = 1'b0;
        redirect_idx = '0;
        exec_ready = 1'b0;
        fence_ack = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        model_q.delete();
    endtask

    task automatic push_entry(input csr_issue_pkg::csr_dis_t e);
        dis_en = 1'b1;
        dis_data = e;
        @(posedge clk);
        #1 dis_en = 1'b0;
        model_q.push_back(e);
        rob_ctr = rob_add(rob_ctr, 1);
    endtask

    task automatic fill_queue(input int n, input logic allow_fence);
        for (int i = 0; i < n; i++) begin
            push_entry(rand_entry(rob_ctr, allow_fence));
        end
    endtask

    // exec_ready stays low in the first cycle while the head moves, then toggles randomly.
    task automatic issue_one(input csr_issue_pkg::csr_dis_t e);
        logic prev_ready;
        logic done;
        commit_rob_idx = e.rob_idx;
        exec_ready = 1'b0;
        prev_ready = 1'b0;
        done = 1'b0;
        for (int cyc = 0; cyc < 100 && !done; cyc++) begin
            @(posedge clk);
            #1;
            check_flag(issue_valid, prev_ready, "issue_valid timing");
            if (issue_valid) begin
                done = 1'b1;
                check_issue(issue_data, csr_issue_pkg::csr_issue_t'(e));
                check_flag(fence_req, needs_serial(e), "fence_req");
                check_inst(trap_inst, e.inst);
            end else begin
                prev_ready = 1'($urandom);
                exec_ready = prev_ready;
            end
        end
        exec_ready = 1'b0;
        if (!done) begin
            errors++;
            $display("error at %0t: entry with ROB index %h was never issued.", $time, e.rob_idx);
        end
    endtask

    task automatic drain_queue();
        while (model_q.size() > 0) begin
            issue_one(model_q.pop_front());
        end
        commit_rob_idx = rob_ctr;
        exec_ready = 1'b1;
        repeat (6) begin
            @(posedge clk);
            #1 check_flag(issue_valid, 1'b0, "issue_valid from an empty queue");
        end
        exec_ready = 1'b0;
    endtask

    function automatic csr_issue_pkg::fence_ctrl_t expect_fence(input logic v, input logic sf,
            input logic inf, input logic mf, input logic fe);
        return '{valid: v, store_flush: sf, inst_flush: inf, mmu_flush: mf,
                 mmu_flush_all: vaddr_m == '0, vma_vaddr: vaddr_m, vma_asid: asid_m,
                 fence_end: fe, rob_idx: fence_rob_m};
    endfunction

    task automatic step_fence(input csr_issue_pkg::fence_ctrl_t exp);
        @(posedge clk);
        #1;
        check_fence(fence_ctrl, exp);
        check_flag(issue_valid, 1'b0, "issue_valid during a fence");
    endtask

    task automatic hold_fence(input csr_issue_pkg::fence_ctrl_t exp);
        repeat ($urandom % 5) step_fence(exp);
    endtask

    // kind 0 is sfence.vma, 1 fence, 2 fence.i and 3 a plain CSR op.
    task automatic run_fence(input int kind, input csr_issue_pkg::rob_idx_t grob);
        commit_fence = 1'b1;
        step_fence(expect_fence(1'b1, kind != 3, 1'b0, 1'b0, kind == 3));
        commit_fence = 1'b0;
        commit_rob_idx = grob; // the next entry is eligible but must wait.
        exec_ready = 1'b1;
        if (kind != 3) begin
            hold_fence(expect_fence(1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
            fence_ack.store_flush_end = 1'b1;
            step_fence(expect_fence(1'b1, 1'b0, kind == 2, kind == 0, kind == 1));
            fence_ack = '0;
            if (kind == 0) begin
                hold_fence(expect_fence(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
                fence_ack.mmu_flush_end = 1'b1;
                step_fence(expect_fence(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
                fence_ack = '0;
            end else if (kind == 2) begin
                hold_fence(expect_fence(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
                fence_ack.inst_flush_end = 1'b1;
                step_fence(expect_fence(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
                fence_ack = '0;
            end
        end
        step_fence(expect_fence(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        exec_ready = 1'b0;
    endtask

    task automatic check_reset_state();
        check_flag(issue_valid, 1'b0, "issue_valid in reset state");
        check_flag(fence_req, 1'b0, "fence_req in reset state");
        check_flag(fence_ctrl.store_flush, 1'b0, "store_flush in reset state");
        check_flag(fence_ctrl.inst_flush, 1'b0, "inst_flush in reset state");
        check_flag(fence_ctrl.mmu_flush, 1'b0, "mmu_flush in reset state");
        check_flag(fence_ctrl.fence_end, 1'b0, "fence_end in reset state");
        check_flag(fence_ctrl.valid, 1'b0, "valid in reset state");
        check_flag(full, 1'b0, "full in reset state");
    endtask

    task automatic start_test();
        test_errs0 = errors;
        reset_dut();
        rob_ctr = csr_issue_pkg::rob_idx_t'(7'($urandom));
        commit_rob_idx = rob_add(rob_ctr, -1);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > test_errs0) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errs0);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        csr_issue_pkg::csr_dis_t f;
        csr_issue_pkg::csr_dis_t g;
        csr_issue_pkg::rob_idx_t first;
        int r;
        logic [csrop_w-1:0] kinds [4];
        clk = 1'b0;
        rst = 1'b1;
        dis_en = 1'b0;
        dis_data = '0;
        commit_rob_idx = '0;
        commit_fence = 1'b0;
        redirect = 1'b0;
        redirect_idx = '0;
        exec_ready = 1'b0;
        fence_ack = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'hf6df));
        kinds = '{csr_issue_pkg::op_sfence, csr_issue_pkg::op_fence, csr_issue_pkg::op_fencei,
                  csr_issue_pkg::op_csrrw};

        start_test();
        repeat (2) begin
            fill_queue(depth, 1'b1);
            drain_queue();
        end
        finish_test("in-order issue");

        start_test();
        exec_ready = 1'b1;
        for (int i = 0; i < depth + 3; i++) begin
            check_flag(full, i >= depth, "full");
            check_flag(issue_valid, 1'b0, "issue_valid while commit holds");
            dis_en = 1'b1;
            dis_data = rand_entry(rob_ctr, 1'b1);
            if (i < depth) begin
                model_q.push_back(dis_data);
                rob_ctr = rob_add(rob_ctr, 1);
            end
            @(posedge clk);
            #1;
        end
        dis_en = 1'b0;
        exec_ready = 1'b0;
        check_flag(full, 1'b1, "full after overfill");
        drain_queue(); // a dropped entry would issue here with the ROB index at commit.
        finish_test("full and back-pressure");

        // the queue pointers carry over between rounds, so the slots wrap as well.
        start_test();
        repeat (3) begin
            rob_ctr = '{wrap: 1'($urandom), idx: 6'(58 + $urandom % 6)}; // near the wrap point.
            commit_rob_idx = rob_add(rob_ctr, -1);
            first = rob_ctr;
            fill_queue(2 + $urandom % (depth - 3), 1'b1);
            r = int'($urandom % (model_q.size() + 1)) - 1;
            redirect_idx = rob_add(first, r);
            redirect = 1'b1;
            @(posedge clk);
            #1 redirect = 1'b0;
            while (model_q.size() > r + 1) begin
                void'(model_q.pop_back());
            end
            rob_ctr = rob_add(first, r + 1);
            fill_queue(2, 1'b1);
            drain_queue();
        end
        finish_test("redirect squash");

        start_test();
        repeat (3) begin
            fill_queue(depth, 1'b0);
            drain_queue();
        end
        finish_test("fence_req decode");

        start_test();
        for (int k = 0; k < 4; k++) begin
            f = rand_entry(rob_ctr, 1'b0);
            f.csrop = kinds[k];
            if (k == 0) begin
                if ($urandom % 2 == 0) begin
                    f.src1 = '0;
                end
                vaddr_m = f.src1[csr_issue_pkg::vaddr_width-1:0];
                asid_m = f.src2[csr_issue_pkg::asid_width-1:0];
            end
            push_entry(f);
            g = rand_entry(rob_ctr, 1'b0);
            push_entry(g);
            model_q.delete();
            fence_rob_m = f.rob_idx;
            issue_one(f);
            run_fence(k, g.rob_idx);
            issue_one(g);
        end
        finish_test("fence sequencing");

        start_test();
        check_reset_state();
        f = rand_entry(rob_ctr, 1'b0);
        f.csrop = csr_issue_pkg::op_fence;
        push_entry(f);
        fill_queue(depth - 1, 1'b0);
        check_flag(full, 1'b1, "full before mid-run reset");
        issue_one(f);
        commit_fence = 1'b1;
        @(posedge clk);
        #1 commit_fence = 1'b0;
        check_flag(fence_ctrl.store_flush, 1'b1, "store_flush before mid-run reset");
        rst = 1'b1;
        #1 check_reset_state();
        @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1 check_reset_state();
        model_q.delete();
        finish_test("reset state");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_top #(
    parameter int queue_depth = 8,
    localparam int qw = $clog2(queue_depth)
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic dis_en,
    input wire csr_issue_pkg::csr_dis_t dis_data,
    input wire csr_issue_pkg::rob_idx_t commit_rob_idx,
    input wire logic commit_fence,
    input wire logic redirect,
    input wire csr_issue_pkg::rob_idx_t redirect_idx,
    input wire logic exec_ready,
    input wire csr_issue_pkg::fence_ack_t fence_ack,
    output logic full,
    output logic issue_valid,
    output csr_issue_pkg::csr_issue_t issue_data,
    output logic fence_req,
    output logic [31:0] trap_inst,
    output csr_issue_pkg::fence_ctrl_t fence_ctrl
);

    logic wr_en;
    logic [qw-1:0] wr_idx;
    logic [qw-1:0] head_idx;
    logic head_wrap;
    logic [qw-1:0] tail_idx;
    logic tail_wrap;
    logic writing;
    logic issue_fire;
    logic fence_busy;
    logic squash_any;
    logic squash_all;
    logic [qw-1:0] restart_idx;
    logic restart_wrap;
    csr_issue_pkg::csr_dis_t head_entry;
    csr_issue_pkg::rob_idx_t [queue_depth-1:0] rob_idx_vec;

    csr_issue_ctrl #(
        .queue_depth(queue_depth)
    ) csr_issue_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .dis_en(dis_en),
        .commit_rob_idx(commit_rob_idx),
        .redirect(redirect),
        .head_entry(head_entry),
        .squash_any(squash_any),
        .squash_all(squash_all),
        .restart_idx(restart_idx),
        .restart_wrap(restart_wrap),
        .fence_busy(fence_busy),
        .exec_ready(exec_ready),
        .full(full),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .head_idx(head_idx),
        .head_wrap(head_wrap),
        .tail_idx(tail_idx),
        .tail_wrap(tail_wrap),
        .writing(writing),
        .issue_fire(issue_fire),
        .issue_valid(issue_valid),
        .issue_data(issue_data),
        .fence_req(fence_req),
        .trap_inst(trap_inst)
    );

    csr_entry_store #(
        .queue_depth(queue_depth)
    ) csr_entry_store_inst (
        .clk(clk),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(dis_data),
        .rd_idx(head_idx),
        .age_idx_all(redirect),
        .rd_data(head_entry),
        .rob_idx_vec(rob_idx_vec)
    );

    csr_squash_locator #(
        .queue_depth(queue_depth)
    ) csr_squash_locator_inst (
        .head_idx(head_idx),
        .head_wrap(head_wrap),
        .tail_idx(tail_idx),
        .tail_wrap(tail_wrap),
        .rob_idx_vec(rob_idx_vec),
        .redirect_idx(redirect_idx),
        .protect_head(writing),
        .squash_any(squash_any),
        .squash_all(squash_all),
        .restart_idx(restart_idx),
        .restart_wrap(restart_wrap)
    );

    fence_sequencer fence_sequencer_inst (
        .clk(clk),
        .rst(rst),
        .issue_fire(issue_fire),
        .issue_entry(head_entry),
        .commit_fence(commit_fence),
        .commit_rob_idx(commit_rob_idx),
        .fence_ack(fence_ack),
        .fence_ctrl(fence_ctrl),
        .fence_busy(fence_busy)
    );

endmodule

`default_nettype wire

/* fence_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fence_sequencer (
    input wire logic clk,
    input wire logic rst,
    input wire logic issue_fire,
    input wire csr_issue_pkg::csr_dis_t issue_entry,
    input wire logic commit_fence,
    input wire csr_issue_pkg::rob_idx_t commit_rob_idx,
    input wire csr_issue_pkg::fence_ack_t fence_ack,
    output csr_issue_pkg::fence_ctrl_t fence_ctrl,
    output logic fence_busy
);

    typedef enum logic [1:0] {fs_idle, fs_store, fs_mmu, fs_inst} fence_state_t;

    fence_state_t state;
    csr_issue_pkg::fence_kind_t kind;
    logic valid;
    logic store_flush;
    logic inst_flush;
    logic mmu_flush;
    logic fence_end;
    logic [csr_issue_pkg::vaddr_width-1:0] vma_vaddr;
    logic [csr_issue_pkg::asid_width-1:0] vma_asid;
    csr_issue_pkg::rob_idx_t fence_rob_idx;

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            kind.sfence_vma <= issue_entry.csrop == csr_issue_pkg::op_sfence;
            kind.fence <= issue_entry.csrop == csr_issue_pkg::op_fence;
            kind.fencei <= issue_entry.csrop == csr_issue_pkg::op_fencei;
            kind.csr_only <= !issue_entry.csrop[csr_issue_pkg::csrop_width-1];
            if (issue_entry.csrop == csr_issue_pkg::op_sfence) begin
                vma_vaddr <= issue_entry.src1[csr_issue_pkg::vaddr_width-1:0];
                vma_asid <= issue_entry.src2[csr_issue_pkg::asid_width-1:0];
            end
        end
        if (commit_fence) begin
            fence_rob_idx <= commit_rob_idx;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fs_idle;
            valid <= 1'b0;
            store_flush <= 1'b0;
            inst_flush <= 1'b0;
            mmu_flush <= 1'b0;
            fence_end <= 1'b0;
        end else begin
            mmu_flush <= 1'b0;
            fence_end <= 1'b0;
            if (fence_end) begin
                valid <= 1'b0;
            end
            case (state)
                fs_idle: begin
                    if (commit_fence) begin
                        valid <= 1'b1;
                        if (kind.csr_only) begin
                            fence_end <= 1'b1; // a plain csr op only needs the pipeline drained.
                        end else begin
                            store_flush <= 1'b1;
                            state <= fs_store;
                        end
                    end
                end
                fs_store: begin
                    if (fence_ack.store_flush_end) begin
                        store_flush <= 1'b0;
                        if (kind.sfence_vma) begin
                            mmu_flush <= 1'b1;
                            state <= fs_mmu;
                        end else if (kind.fencei) begin
                            inst_flush <= 1'b1;
                            state <= fs_inst;
                        end else begin
                            fence_end <= 1'b1;
                            state <= fs_idle;
                        end
                    end
                end
                fs_mmu: begin
                    if (fence_ack.mmu_flush_end) begin
                        fence_end <= 1'b1;
                        state <= fs_idle;
                    end
                end
                default: begin
                    if (fence_ack.inst_flush_end) begin
                        inst_flush <= 1'b0;
                        fence_end <= 1'b1;
                        state <= fs_idle;
                    end
                end
            endcase
        end
    end

    assign fence_busy = valid;

    // a zero address on sfence.vma flushes every translation.
    assign fence_ctrl = '{
        valid: valid,
        store_flush: store_flush,
        inst_flush: inst_flush,
        mmu_flush: mmu_flush,
        mmu_flush_all: vma_vaddr == '0,
        vma_vaddr: vma_vaddr,
        vma_asid: vma_asid,
        fence_end: fence_end,
        rob_idx: fence_rob_idx
    };

    // issue is blocked while valid is high, so commit cannot present a second fence.
    assert property (@(posedge clk) disable iff (rst) commit_fence |-> !valid)
        else $error("commit_fence arrived while a fence sequence was running.");

endmodule

`default_nettype wire

/* csr_squash_locator.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_squash_locator #(
    parameter int queue_depth = 8,
    localparam int qw = $clog2(queue_depth)
) (
    input wire logic [qw-1:0] head_idx,
    input wire logic head_wrap,
    input wire logic [qw-1:0] tail_idx,
    input wire logic tail_wrap,
    input wire csr_issue_pkg::rob_idx_t [queue_depth-1:0] rob_idx_vec,
    input wire csr_issue_pkg::rob_idx_t redirect_idx,
    input wire logic protect_head,
    output logic squash_any,
    output logic squash_all,
    output logic [qw-1:0] restart_idx,
    output logic restart_wrap
);

    // both vectors are kept in age order, bit 0 being the head slot.
    logic [queue_depth-1:0] aged_live;
    logic [queue_depth-1:0] aged_young;
    logic run_ok;

    // a differing wrap bit means the index space has rolled over between the two.
    function automatic logic is_younger(input csr_issue_pkg::rob_idx_t a,
                                        input csr_issue_pkg::rob_idx_t b);
        return a.wrap == b.wrap ? a.idx > b.idx : a.idx < b.idx;
    endfunction

    always_comb begin
        int count;
        int slot;
        count = head_wrap == tail_wrap ? int'(tail_idx) - int'(head_idx)
                                       : queue_depth - int'(head_idx) + int'(tail_idx);
        for (int k = 0; k < queue_depth; k++) begin
            slot = (int'(head_idx) + k) % queue_depth;
            aged_live[k] = k < count;
            aged_young[k] = aged_live[k] && !(protect_head && k == 0) &&
                            is_younger(rob_idx_vec[slot], redirect_idx);
        end
    end

    assign squash_any = |aged_young;
    assign squash_all = squash_any && aged_young == aged_live;

    always_comb begin
        int first;
        int pos;
        first = queue_depth - 1;
        for (int k = queue_depth - 1; k >= 0; k--) begin
            if (aged_young[k]) begin
                first = k;
            end
        end
        pos = int'(head_idx) + first;
        restart_idx = qw'(pos % queue_depth);
        restart_wrap = pos >= queue_depth ? !head_wrap : head_wrap; // slot sits before the head.
    end

    always_comb begin
        run_ok = 1'b1;
        for (int k = 0; k < queue_depth - 1; k++) begin
            if (aged_young[k] && aged_live[k + 1] && !aged_young[k + 1]) begin
                run_ok = 1'b0;
            end
        end
    end

    // entries sit in program order, so a squash always cuts off one run at the tail.
    always_comb begin
        assert final ($isunknown(aged_young) || run_ok)
            else $error("younger entries do not form one run ending at the tail.");
    end

endmodule

`default_nettype wire

/* csr_entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_entry_store #(
    parameter int queue_depth = 8,
    localparam int qw = $clog2(queue_depth)
) (
    input wire logic clk,
    input wire logic wr_en,
    input wire logic [qw-1:0] wr_idx,
    input wire csr_issue_pkg::csr_dis_t wr_data,
    input wire logic [qw-1:0] rd_idx,
    input wire logic age_idx_all,
    output csr_issue_pkg::csr_dis_t rd_data,
    output csr_issue_pkg::rob_idx_t [queue_depth-1:0] rob_idx_vec
);

    csr_issue_pkg::csr_dis_t mem [queue_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx];

    // the slot indices only matter during a redirect, so the age comparators idle otherwise.
    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            rob_idx_vec[i] = age_idx_all ? mem[i].rob_idx : '0;
        end
    end

endmodule

`default_nettype wire

/* csr_issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_ctrl #(
    parameter int queue_depth = 8,
    localparam int qw = $clog2(queue_depth)
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic dis_en,
    input wire csr_issue_pkg::rob_idx_t commit_rob_idx,
    input wire logic redirect,
    input wire csr_issue_pkg::csr_dis_t head_entry,
    input wire logic squash_any,
    input wire logic squash_all,
    input wire logic [qw-1:0] restart_idx,
    input wire logic restart_wrap,
    input wire logic fence_busy,
    input wire logic exec_ready,
    output logic full,
    output logic wr_en,
    output logic [qw-1:0] wr_idx,
    output logic [qw-1:0] head_idx,
    output logic head_wrap,
    output logic [qw-1:0] tail_idx,
    output logic tail_wrap,
    output logic writing,
    output logic issue_fire,
    output logic issue_valid,
    output csr_issue_pkg::csr_issue_t issue_data,
    output logic fence_req,
    output logic [31:0] trap_inst
);

    localparam logic [qw-1:0] last_slot = qw'(queue_depth - 1);

    typedef enum logic {st_idle, st_writing} state_t;

    state_t state;
    csr_issue_pkg::rob_idx_t write_rob_idx;
    logic empty;
    logic head_move;

    // csrrs and csrrc with a zero source are not told apart from real writes.
    function automatic logic needs_fence(input csr_issue_pkg::csr_dis_t e);
        logic pmp;
        pmp = e.csr_id >= csr_issue_pkg::csr_pmp_base && e.csr_id < csr_issue_pkg::csr_pmp_limit;
        return e.csrop[csr_issue_pkg::csrop_width-1] ||
               e.csr_id == csr_issue_pkg::csr_mstatus ||
               e.csr_id == csr_issue_pkg::csr_sstatus ||
               e.csr_id == csr_issue_pkg::csr_satp ||
               e.csr_id == csr_issue_pkg::csr_fcsr || pmp;
    endfunction

    assign empty = head_idx == tail_idx && head_wrap == tail_wrap;
    assign full = head_idx == tail_idx && head_wrap != tail_wrap;
    assign wr_en = dis_en && !full && !redirect;
    assign wr_idx = tail_idx;
    assign writing = state == st_writing; // the issued head is shielded from a squash.

    // only the head may issue, and only once it is the oldest instruction in flight.
    assign issue_fire = !empty && state == st_idle && head_entry.rob_idx == commit_rob_idx &&
                        !redirect && !fence_busy && exec_ready;
    assign head_move = state == st_writing && commit_rob_idx != write_rob_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            write_rob_idx <= '0;
            head_idx <= '0;
            head_wrap <= 1'b0;
            issue_valid <= 1'b0;
            fence_req <= 1'b0;
        end else begin
            issue_valid <= issue_fire;
            if (issue_fire) begin
                state <= st_writing;
                write_rob_idx <= head_entry.rob_idx;
                fence_req <= needs_fence(head_entry);
            end else if (head_move) begin
                state <= st_idle; // commit has moved past the issued entry.
                fence_req <= 1'b0;
                head_idx <= head_idx == last_slot ? '0 : head_idx + 1'b1;
                if (head_idx == last_slot) begin
                    head_wrap <= !head_wrap;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue_data <= csr_issue_pkg::csr_issue_t'(head_entry);
            trap_inst <= head_entry.inst;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_idx <= '0;
            tail_wrap <= 1'b0;
        end else if (redirect) begin
            if (squash_all) begin
                tail_idx <= head_idx;
                tail_wrap <= head_wrap;
            end else if (squash_any) begin
                tail_idx <= restart_idx;
                tail_wrap <= restart_wrap;
            end
        end else if (wr_en) begin
            tail_idx <= tail_idx == last_slot ? '0 : tail_idx + 1'b1;
            if (tail_idx == last_slot) begin
                tail_wrap <= !tail_wrap;
            end
        end
    end

    // an issue holds the head until commit moves on, so issues never come back to back.
    assert property (@(posedge clk) disable iff (rst) issue_valid |=> !issue_valid)
        else $error("issue_valid pulsed on two consecutive cycles.");

    assert property (@(posedge clk) disable iff (rst)
        head_wrap != tail_wrap |-> tail_idx <= head_idx)
        else $error("tail pointer passed the head pointer.");

endmodule

`default_nettype wire

/* csr_issue_pkg.sv */
`default_nettype none

package csr_issue_pkg;

    localparam int xlen = 64;
    localparam int rob_width = 7; // six index bits and the wrap bit.
    localparam int csrop_width = 4;
    localparam int csr_id_width = 12;
    localparam int preg_width = 7;
    localparam int vaddr_width = 39;
    localparam int asid_width = 16;

    typedef struct packed {
        logic wrap;
        logic [rob_width-2:0] idx;
    } rob_idx_t;

    // the top bit of the operation code marks the fence kinds.
    localparam logic [csrop_width-1:0] op_csrrw = 4'h1;
    localparam logic [csrop_width-1:0] op_csrrs = 4'h2;
    localparam logic [csrop_width-1:0] op_csrrc = 4'h3;
    localparam logic [csrop_width-1:0] op_fence = 4'h8;
    localparam logic [csrop_width-1:0] op_fencei = 4'h9;
    localparam logic [csrop_width-1:0] op_sfence = 4'ha;

    localparam logic [csr_id_width-1:0] csr_mstatus = 12'h300;
    localparam logic [csr_id_width-1:0] csr_sstatus = 12'h100;
    localparam logic [csr_id_width-1:0] csr_satp = 12'h180;
    localparam logic [csr_id_width-1:0] csr_fcsr = 12'h003;
    localparam logic [csr_id_width-1:0] csr_pmp_base = 12'h3a0;
    localparam logic [csr_id_width-1:0] csr_pmp_limit = 12'h3f0; // first id past the pmp range.

    typedef struct packed {
        logic we;
        logic [preg_width-1:0] rd;
        rob_idx_t rob_idx;
        logic [csrop_width-1:0] csrop;
        logic [csr_id_width-1:0] csr_id;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [31:0] inst;
    } csr_dis_t;

    typedef struct packed {
        logic we;
        logic [preg_width-1:0] rd;
        rob_idx_t rob_idx;
        logic [csrop_width-1:0] csrop;
        logic [csr_id_width-1:0] csr_id;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [31:0] inst;
    } csr_issue_t;

    typedef struct packed {
        logic sfence_vma;
        logic fence;
        logic fencei;
        logic csr_only;
    } fence_kind_t;

    typedef struct packed {
        logic valid;
        logic store_flush;
        logic inst_flush;
        logic mmu_flush;
        logic mmu_flush_all;
        logic [vaddr_width-1:0] vma_vaddr;
        logic [asid_width-1:0] vma_asid;
        logic fence_end;
        rob_idx_t rob_idx;
    } fence_ctrl_t;

    typedef struct packed {
        logic store_flush_end;
        logic mmu_flush_end;
        logic inst_flush_end;
    } fence_ack_t;

endpackage

`default_nettype wire
